/* ahb_pkg.sv */
package ahb_pkg;

    // AHB burst codes. Only WRAP4 is handled as a burst here.
    typedef enum logic [2:0] {
        SINGLE = 3'b000,
        INCR   = 3'b001,
        WRAP4  = 3'b010
    } burst_e;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } trans_e;

    // Address phase from the master.
    typedef struct packed {
        logic        hsel;
        logic [31:0] haddr;
        trans_e      htrans;
        logic        hwrite;
        burst_e      hburst;
    } ahb_req_t;

    typedef struct packed {
        logic [31:0] hrdata;
        logic        hreadyout;
        logic        hresp; // 0 is OKAY.
    } ahb_rsp_t;

    // One accepted beat, handed to the data phase.
    typedef struct packed {
        logic        valid;
        logic        write;
        logic        is_cfg;
        logic [29:0] word_addr;
    } beat_t;

    typedef struct packed {
        logic [1:0] wait_states;
    } cfg_t;

    localparam logic [31:0] CFG_ADDR = 32'h0000_1000; // At or above selects the register.
    localparam int WRAP_BYTES = 16;

endpackage

/* ahb_sram.sv */
`timescale 1ns/1ps

module ahb_sram #(
    parameter int MEM_WORDS = 256
) (
    input  logic        clk,
    input  logic        we,
    input  logic [29:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata
);

    localparam int AW = $clog2(MEM_WORDS);

    logic [31:0] mem [MEM_WORDS];
    logic [AW-1:0] idx;

    assign idx = addr[AW-1:0];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= wdata;
        end
    end

    // Async read, so a write shows up on the next cycle's read.
    assign rdata = mem[idx];

endmodule

/* ahb_wait_cfg.sv */
`timescale 1ns/1ps

module ahb_wait_cfg (
    input  logic          clk,
    input  logic          rstn,
    input  logic          wr_en,
    input  logic [31:0]   wr_data,
    output ahb_pkg::cfg_t cfg
);

    localparam int CFG_W = $bits(ahb_pkg::cfg_t);

    ahb_pkg::cfg_t cfg_q;

    // Written at the edge that completes a config write beat.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cfg_q <= '0;
        end else if (wr_en) begin
            cfg_q <= ahb_pkg::cfg_t'(wr_data[CFG_W-1:0]); // Upper bits ignored.
        end
    end

    // Same value steers the data phase and reads back.
    assign cfg = cfg_q;

endmodule

/* ahb_burst_addr.sv */
`timescale 1ns/1ps

module ahb_burst_addr #(
    parameter int MEM_WORDS = 256
) (
    input  logic             clk,
    input  logic             rstn,
    input  ahb_pkg::ahb_req_t req,
    input  logic             hready,
    output ahb_pkg::beat_t   beat
);

    localparam int AW    = $clog2(MEM_WORDS);
    localparam int OFS_W = $clog2(ahb_pkg::WRAP_BYTES);

    logic              accept;
    logic              is_nonseq;
    logic              seq_wrap;
    logic              wrap_on;
    logic [1:0]        beat_cnt;
    logic [31:0]       wrap_base;
    logic [OFS_W-1:0]  wrap_ofs;
    logic [OFS_W-1:0]  ofs_nxt;
    logic [31:0]       byte_addr;
    logic [29:0]       word_addr;

    assign is_nonseq = (req.htrans == ahb_pkg::NONSEQ);
    assign accept    = req.hsel && hready && (is_nonseq || req.htrans == ahb_pkg::SEQ);

    // SEQ beats of a live WRAP4 burst take the generated address.
    assign seq_wrap  = !is_nonseq && wrap_on && (beat_cnt != 2'd3);
    assign ofs_nxt   = wrap_ofs + OFS_W'(4); // Rolls over at the window edge.
    assign byte_addr = seq_wrap ? (wrap_base | 32'(ofs_nxt)) : req.haddr;

    // MEM_WORDS is a power of two, so masking keeps the index in range.
    assign word_addr = 30'(byte_addr[AW+1:2]);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wrap_on  <= 1'b0;
            beat_cnt <= 2'd0;
        end else if (accept) begin
            if (is_nonseq) begin
                wrap_on  <= (req.hburst == ahb_pkg::WRAP4);
                beat_cnt <= 2'd0;
            end else if (seq_wrap) begin
                beat_cnt <= beat_cnt + 2'd1;
            end
        end
    end

    // Window base and offset within it.
    always_ff @(posedge clk) begin
        if (accept && is_nonseq) begin
            wrap_base <= req.haddr & ~32'(ahb_pkg::WRAP_BYTES - 1);
            wrap_ofs  <= req.haddr[OFS_W-1:0];
        end else if (accept && seq_wrap) begin
            wrap_ofs  <= ofs_nxt;
        end
    end

    // Beat holds through wait states, since nothing is accepted then.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat <= '0;
        end else if (hready) begin
            beat.valid <= accept;
            if (accept) begin
                beat.write     <= req.hwrite;
                beat.is_cfg    <= (byte_addr >= ahb_pkg::CFG_ADDR);
                beat.word_addr <= word_addr;
            end
        end
    end

endmodule

/* ahb_data_ctrl.sv */
`timescale 1ns/1ps

module ahb_data_ctrl (
    input  logic              clk,
    input  logic              rstn,
    input  ahb_pkg::beat_t    beat,
    input  ahb_pkg::cfg_t     cfg,
    input  logic [31:0]       hwdata,
    input  logic [31:0]       mem_rdata,
    output logic              mem_we,
    output logic [29:0]       mem_addr,
    output logic [31:0]       mem_wdata,
    output logic              cfg_we,
    output logic [31:0]       cfg_wdata,
    output ahb_pkg::ahb_rsp_t rsp
);

    logic [1:0] wait_cnt;
    logic       stall;
    logic       done;
    logic       wr_done;

    // Wait until the counter reaches the programmed count.
    assign stall   = beat.valid && (wait_cnt < cfg.wait_states);
    assign done    = beat.valid && !stall;
    assign wr_done = done && beat.write;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wait_cnt <= 2'd0;
        end else if (done) begin
            wait_cnt <= 2'd0; // Next beat starts fresh.
        end else if (stall) begin
            wait_cnt <= wait_cnt + 2'd1;
        end
    end

    assign mem_addr  = beat.word_addr;
    assign mem_wdata = hwdata;
    assign mem_we    = wr_done && !beat.is_cfg;

    assign cfg_wdata = hwdata;
    assign cfg_we    = wr_done && beat.is_cfg;

    // Read data comes straight off the SRAM or the register.
    always_comb begin
        rsp.hreadyout = !stall;
        rsp.hresp     = 1'b0;
        if (beat.is_cfg) begin
            rsp.hrdata = 32'(cfg.wait_states);
        end else begin
            rsp.hrdata = mem_rdata;
        end
    end

endmodule

/* ahb_mem_top.sv */
`timescale 1ns/1ps

module ahb_mem_top #(
    parameter int MEM_WORDS = 256
) (
    input  logic              clk,
    input  logic              rstn,
    input  ahb_pkg::ahb_req_t req,
    input  logic [31:0]       hwdata,
    input  logic              hready,
    output ahb_pkg::ahb_rsp_t rsp
);

    ahb_pkg::beat_t beat;
    ahb_pkg::cfg_t  cfg;

    logic        mem_we;
    logic [29:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;
    logic        cfg_we;
    logic [31:0] cfg_wdata;

    ahb_burst_addr #(
        .MEM_WORDS (MEM_WORDS)
    ) burst_addr_i (
        .clk    (clk),
        .rstn   (rstn),
        .req    (req),
        .hready (hready),
        .beat   (beat)
    );

    ahb_wait_cfg wait_cfg_i (
        .clk     (clk),
        .rstn    (rstn),
        .wr_en   (cfg_we),
        .wr_data (cfg_wdata),
        .cfg     (cfg)
    );

    ahb_data_ctrl data_ctrl_i (
        .clk       (clk),
        .rstn      (rstn),
        .beat      (beat),
        .cfg       (cfg),
        .hwdata    (hwdata),
        .mem_rdata (mem_rdata),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .cfg_we    (cfg_we),
        .cfg_wdata (cfg_wdata),
        .rsp       (rsp)
    );

    ahb_sram #(
        .MEM_WORDS (MEM_WORDS)
    ) sram_i (
        .clk   (clk),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

/* ahb_mem_assert.sv */
`timescale 1ns/1ps

module ahb_mem_assert (
    input logic              clk,
    input logic              rstn,
    input ahb_pkg::ahb_rsp_t rsp,
    input ahb_pkg::cfg_t     cfg
);

    logic [2:0] low_cnt; // Consecutive cycles with hreadyout low.

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            low_cnt <= 3'd0;
        end else if (!rsp.hreadyout) begin
            low_cnt <= low_cnt + 3'd1;
        end else begin
            low_cnt <= 3'd0;
        end
    end

    ready_after_reset: assert property (@(posedge clk) $rose(rstn) |-> rsp.hreadyout)
        else $error("hreadyout is low right after reset");

    wait_bound: assert property (@(posedge clk) disable iff (!rstn)
        !rsp.hreadyout |-> (low_cnt < 3'(cfg.wait_states)))
        else $error("hreadyout low for longer than the programmed wait states");

    resp_okay: assert property (@(posedge clk) disable iff (!rstn) rsp.hresp == 1'b0)
        else $error("hresp is not OKAY");

endmodule

bind ahb_data_ctrl ahb_mem_assert assert_i (
    .clk  (clk),
    .rstn (rstn),
    .rsp  (rsp),
    .cfg  (cfg)
);

/* tb_ahb_mem.sv */
`timescale 1ns/1ps

module tb_ahb_mem;

    localparam int MEM_WORDS    = 256;
    localparam int NUM_XFERS    = 12;
    localparam int CLK_NS       = 20;
    localparam int RESET_CYCLES = 16;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_XFERS * 4 * 5) * CLK_NS;

    typedef struct packed {
        ahb_pkg::burst_e  kind;
        logic             write;
        logic [31:0]      addr;
        logic [3:0][31:0] data;
        logic [1:0]       wait_states;
    } xfer_t;

    logic              clk;
    logic              rstn;
    ahb_pkg::ahb_req_t req;
    logic [31:0]       hwdata;
    logic              hready;
    ahb_pkg::ahb_rsp_t rsp;
    ahb_pkg::ahb_rsp_t rsp_s; // Sampled at the falling edge.

    xfer_t       xfers [NUM_XFERS];
    logic [31:0] ref_mem [MEM_WORDS];
    logic [1:0]  cur_wait; // Model of the config register.
    int unsigned seed_ret;

    ahb_mem_top #(
        .MEM_WORDS (MEM_WORDS)
    ) dut_i (
        .clk    (clk),
        .rstn   (rstn),
        .req    (req),
        .hwdata (hwdata),
        .hready (hready),
        .rsp    (rsp)
    );

    assign hready = rsp.hreadyout; // Single slave.

    initial clk = 1'b0;
    always #(CLK_NS / 2) clk = ~clk;

    task automatic check_rsp(input ahb_pkg::ahb_rsp_t act, input ahb_pkg::ahb_rsp_t rsp_exp,
                             input logic with_data);
        logic bad;
        bad = (act.hreadyout !== rsp_exp.hreadyout) || (act.hresp !== rsp_exp.hresp);
        if (with_data && (act.hrdata !== rsp_exp.hrdata)) bad = 1'b1;
        if (bad) begin
            $display("MISMATCH at %0t: rsp hrdata %h hreadyout %b hresp %b, expected %h %b %b",
                     $time, act.hrdata, act.hreadyout, act.hresp,
                     rsp_exp.hrdata, rsp_exp.hreadyout, rsp_exp.hresp);
            $display("Some tests failed");
            $fatal(1, "Response mismatch.");
        end
    endtask

    task automatic check_cfg(input ahb_pkg::cfg_t act, input ahb_pkg::cfg_t cfg_exp);
        if (act !== cfg_exp) begin
            $display("MISMATCH at %0t: cfg wait_states %0d, expected %0d",
                     $time, act.wait_states, cfg_exp.wait_states);
            $display("Some tests failed");
            $fatal(1, "Config mismatch.");
        end
    endtask

    task automatic check_cycles(input int act, input int cyc_exp);
        if (act != cyc_exp) begin
            $display("MISMATCH at %0t: beat took %0d cycles, expected %0d", $time, act, cyc_exp);
            $display("Some tests failed");
            $fatal(1, "Beat length mismatch.");
        end
    endtask

    // One clock: sample mid-cycle, then drive 1 ns past the rising edge.
    task automatic step();
        @(negedge clk);
        rsp_s = rsp;
        @(posedge clk);
        #1;
    endtask

    task automatic set_xfer(input int i, input ahb_pkg::burst_e kind, input logic wr,
                            input logic [31:0] addr, input logic [1:0] w);
        xfers[i].kind        = kind;
        xfers[i].write       = wr;
        xfers[i].addr        = addr;
        xfers[i].wait_states = w;
        for (int k = 0; k < 4; k++) begin
            xfers[i].data[k] = $urandom();
        end
    endtask

    // Drives one SINGLE or WRAP4 transfer and checks every data phase.
    task automatic run_xfer(input xfer_t x);
        int                n;
        int                cycles;
        logic              is_cfg;
        logic [31:0]       base;
        logic [31:0]       addr_q [4];
        ahb_pkg::ahb_rsp_t rsp_exp;
        n    = (x.kind == ahb_pkg::WRAP4) ? 4 : 1;
        base = x.addr & ~32'(ahb_pkg::WRAP_BYTES - 1);
        for (int k = 0; k < 4; k++) begin
            addr_q[k] = base | ((x.addr + 32'(4 * k)) & 32'(ahb_pkg::WRAP_BYTES - 1));
        end
        req.hsel   = 1'b1;
        req.haddr  = x.addr;
        req.htrans = ahb_pkg::NONSEQ;
        req.hwrite = x.write;
        req.hburst = x.kind;
        step();
        while (!rsp_s.hreadyout) step();
        for (int k = 0; k < n; k++) begin
            hwdata = x.write ? x.data[k] : 32'h0;
            if (k + 1 < n) begin
                req.htrans = ahb_pkg::SEQ;
                req.haddr  = addr_q[k + 1] ^ 32'h0000_0340; // Wrong on purpose.
            end else begin
                req.hsel   = 1'b0;
                req.htrans = ahb_pkg::IDLE;
                req.hburst = ahb_pkg::SINGLE;
            end
            cycles = 1;
            step();
            while (!rsp_s.hreadyout) begin
                step();
                cycles++;
            end
            check_cycles(cycles, 1 + int'(cur_wait));
            is_cfg            = (addr_q[k] >= ahb_pkg::CFG_ADDR);
            rsp_exp.hreadyout = 1'b1;
            rsp_exp.hresp     = 1'b0;
            if (is_cfg) rsp_exp.hrdata = 32'(cur_wait);
            else rsp_exp.hrdata = ref_mem[(addr_q[k] >> 2) % MEM_WORDS];
            check_rsp(rsp_s, rsp_exp, !x.write);
            if (x.write && is_cfg) cur_wait = x.data[k][1:0];
            else if (x.write) ref_mem[(addr_q[k] >> 2) % MEM_WORDS] = x.data[k];
        end
    endtask

    initial begin
        xfer_t             cw;
        ahb_pkg::ahb_rsp_t idle_rsp;
        seed_ret = $urandom(32'h9d15acae);
        rstn     = 1'b0;
        req      = '0;
        hwdata   = 32'h0;
        cur_wait = 2'd0;
        set_xfer(0, ahb_pkg::SINGLE, 1'b1, 32'h0000_0000, 2'd0);
        set_xfer(1, ahb_pkg::SINGLE, 1'b1, 32'h0000_0004, 2'd1);
        set_xfer(2, ahb_pkg::SINGLE, 1'b0, 32'h0000_0000, 2'd2);
        set_xfer(3, ahb_pkg::SINGLE, 1'b0, 32'h0000_0004, 2'd0);
        set_xfer(4, ahb_pkg::WRAP4, 1'b1, 32'h0000_0028, 2'd0);  // Offsets 8, C, 0, 4.
        set_xfer(5, ahb_pkg::WRAP4, 1'b0, 32'h0000_0028, 2'd0);
        set_xfer(6, ahb_pkg::WRAP4, 1'b0, 32'h0000_0024, 2'd1);
        set_xfer(7, ahb_pkg::WRAP4, 1'b1, 32'h0000_0108, 2'd3);
        set_xfer(8, ahb_pkg::SINGLE, 1'b0, 32'h0000_010c, 2'd2);
        set_xfer(9, ahb_pkg::WRAP4, 1'b0, 32'h0000_0100, 2'd3);
        set_xfer(10, ahb_pkg::SINGLE, 1'b1, 32'h0000_03fc, 2'd1);
        set_xfer(11, ahb_pkg::SINGLE, 1'b0, 32'h0000_03fc, 2'd0);
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstn = 1'b1;
        step();
        idle_rsp = '{hrdata: 32'h0, hreadyout: 1'b1, hresp: 1'b0};
        check_rsp(rsp_s, idle_rsp, 1'b0);
        for (int i = 0; i < NUM_XFERS; i++) begin
            // Program the wait count, with junk in the unused upper bits.
            cw         = '0;
            cw.kind    = ahb_pkg::SINGLE;
            cw.write   = 1'b1;
            cw.addr    = ahb_pkg::CFG_ADDR;
            cw.data[0] = ($urandom() & 32'hffff_fffc) | 32'(xfers[i].wait_states);
            run_xfer(cw);
            // Register takes the new count at the completing edge.
            check_cfg(dut_i.cfg, ahb_pkg::cfg_t'(xfers[i].wait_states));
            cw.write = 1'b0;
            run_xfer(cw);
            run_xfer(xfers[i]);
        end
        step();
        step();
        $display("All tests passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the transfers did not finish in the expected time.");
        $display("Some tests failed");
        $fatal(1, "Watchdog expired.");
    end

endmodule

/* list.f */
ahb_pkg.sv
ahb_sram.sv
ahb_wait_cfg.sv
ahb_burst_addr.sv
ahb_data_ctrl.sv
ahb_mem_top.sv
ahb_mem_assert.sv
tb_ahb_mem.sv
